// File: Makefile
TOP := tb_mips

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_valid,
  input  logic [31:0] i_pc_plus4,
  input  instr_u      i_instr,
  input  logic        i_flush,
  input  logic        i_wb_we,
  input  logic [4:0]  i_wb_reg,
  input  logic [31:0] i_wb_data,
  output logic        o_predict_taken,
  output logic [31:0] o_predict_target,
  dx_if.src           dx
);

  logic [31:0] regs [32];
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] id_imm;
  logic [31:0] id_target;
  logic [4:0]  id_dest;
  ctrl_t       id_ctrl;

  // Register 0 is never stored
  always_ff @(posedge clk) begin
    if (i_wb_we && (i_wb_reg != 5'd0)) regs[i_wb_reg] <= i_wb_data;
  end

  // Same-cycle writeback passes straight through
  function automatic logic [31:0] read_reg(input logic [4:0] addr);
    logic [31:0] data;
    if (addr == 5'd0) data = '0;
    else if (i_wb_we && (i_wb_reg == addr)) data = i_wb_data;
    else data = regs[addr];
    return data;
  endfunction

  always_comb begin
    rs_data = read_reg(i_instr.r.rs);
    rt_data = read_reg(i_instr.r.rt);
  end

  always_comb begin
    id_ctrl = '0;
    id_dest = i_instr.r.rd;
    case (i_instr.r.opcode)
      OP_RTYPE: begin
        id_ctrl.reg_write = 1'b1;
        case (i_instr.r.funct)
          FN_ADD:  id_ctrl.alu_op = ALU_ADD;
          FN_SUB:  id_ctrl.alu_op = ALU_SUB;
          FN_AND:  id_ctrl.alu_op = ALU_AND;
          FN_OR:   id_ctrl.alu_op = ALU_OR;
          FN_SLT:  id_ctrl.alu_op = ALU_SLT;
          default: id_ctrl.reg_write = 1'b0;  // Nop and unsupported codes
        endcase
      end
      OP_ADDI, OP_LW: begin
        id_ctrl.alu_src   = 1'b1;
        id_ctrl.reg_write = 1'b1;
        id_ctrl.mem_read  = (i_instr.i.opcode == OP_LW);
        id_dest           = i_instr.i.rt;
      end
      OP_SW: begin
        id_ctrl.alu_src   = 1'b1;
        id_ctrl.mem_write = 1'b1;
      end
      OP_BEQ: begin
        id_ctrl.alu_op = ALU_SUB;
        id_ctrl.branch = 1'b1;
      end
      default: id_ctrl = '0;
    endcase
    if (id_dest == 5'd0) id_ctrl.reg_write = 1'b0;  // Writes to r0 are dropped here
  end

  assign id_imm    = {{16{i_instr.i.imm[15]}}, i_instr.i.imm};
  assign id_target = i_pc_plus4 + {id_imm[29:0], 2'b00};

  // Backward beq is predicted taken
  assign o_predict_taken  = i_valid && (i_instr.i.opcode == OP_BEQ) && i_instr.i.imm[15];
  assign o_predict_target = id_target;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) dx.valid <= 1'b0;
    else dx.valid <= i_valid && !i_flush;
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    dx.pc_plus4        <= i_pc_plus4;
    dx.rs_data         <= rs_data;
    dx.rt_data         <= rt_data;
    dx.imm             <= id_imm;
    dx.dest            <= id_dest;
    dx.ctrl            <= id_ctrl;
    dx.predicted_taken <= o_predict_taken;
    dx.branch_target   <= id_target;
  end

  // Memory stage never targets r0
  a_no_r0_write: assert property (
    @(posedge clk) disable iff (!i_rst_n) i_wb_we |-> (i_wb_reg != 5'd0));

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
  import mips_pipe_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  dx_if.dst           dx,
  output logic        o_mispredict,
  output logic [31:0] o_redirect_pc,
  xm_if.src           xm
);

  logic [31:0] op_b;
  logic [31:0] alu_result;
  logic        taken;

  assign op_b = dx.ctrl.alu_src ? dx.imm : dx.rt_data;

  always_comb begin
    case (dx.ctrl.alu_op)
      ALU_ADD: alu_result = dx.rs_data + op_b;
      ALU_SUB: alu_result = dx.rs_data - op_b;
      ALU_AND: alu_result = dx.rs_data & op_b;
      ALU_OR:  alu_result = dx.rs_data | op_b;
      ALU_SLT: alu_result = {31'd0, $signed(dx.rs_data) < $signed(op_b)};
      default: alu_result = '0;
    endcase
  end

  // beq resolves here
  assign taken         = (dx.rs_data == dx.rt_data);
  assign o_mispredict  = dx.valid && dx.ctrl.branch && (taken != dx.predicted_taken);
  assign o_redirect_pc = taken ? dx.branch_target : dx.pc_plus4;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) xm.valid <= 1'b0;
    else xm.valid <= dx.valid;
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    xm.alu_result <= alu_result;
    xm.store_data <= dx.rt_data;
    xm.dest       <= dx.dest;
    xm.ctrl       <= dx.ctrl;
  end

  // The flush empties the next EX slot, so pulses are single cycles
  a_mispredict_branch: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    o_mispredict |=> !dx.valid);

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module fetch_stage
  import mips_isa_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_imem_we,
  input  logic [5:0]  i_imem_addr,
  input  logic [31:0] i_imem_wdata,
  input  logic        i_predict_taken,
  input  logic [31:0] i_predict_target,
  input  logic        i_mispredict,
  input  logic [31:0] i_redirect_pc,
  output logic        o_valid,
  output logic [31:0] o_pc_plus4,
  output instr_u      o_instr
);

  localparam int unsigned IMEM_AW = $clog2(`MIPS_IMEM_DEPTH);

  logic [31:0] imem [`MIPS_IMEM_DEPTH];
  logic [31:0] pc;
  logic [31:0] pc_plus4;
  logic [31:0] pc_next;

  // Loaded from the top level while the core sits in reset
  always_ff @(posedge clk) begin
    if (i_imem_we) imem[i_imem_addr[IMEM_AW-1:0]] <= i_imem_wdata;
  end

  assign pc_plus4 = pc + 32'd4;
  assign pc_next  = i_mispredict    ? i_redirect_pc    :  // Execute overrides decode
                    i_predict_taken ? i_predict_target :
                                      pc_plus4;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc      <= `MIPS_RESET_PC;
      o_valid <= 1'b0;
    end else begin
      pc      <= pc_next;
      o_valid <= !(i_mispredict || i_predict_taken);  // Drop the wrong-path fetch
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    o_pc_plus4 <= pc_plus4;
    o_instr    <= imem[pc[IMEM_AW+1:2]];
  end

  // Program loading and a running pipeline are never mixed
  a_no_load_while_running: assert property (
    @(posedge clk) disable iff (!i_rst_n) !(i_mispredict && i_imem_we));

endmodule

`default_nettype wire

// File: hdl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mips_cfg.svh"

module memory_stage (
  input  logic        clk,
  input  logic        i_rst_n,
  xm_if.dst           xm,
  output logic        o_wb_we,
  output logic [4:0]  o_wb_reg,
  output logic [31:0] o_wb_data
);

  localparam int unsigned DMEM_AW = $clog2(`MIPS_DMEM_DEPTH);

  logic [31:0]        dmem [`MIPS_DMEM_DEPTH];
  logic [DMEM_AW-1:0] word_addr;
  logic [31:0]        load_data;
  logic [31:0]        mw_alu_result;
  logic [31:0]        mw_load_data;
  logic               mw_mem_read;

  assign word_addr = xm.alu_result[DMEM_AW+1:2];
  assign load_data = dmem[word_addr];  // Asynchronous read

  always_ff @(posedge clk) begin
    if (xm.valid && xm.ctrl.mem_write) dmem[word_addr] <= xm.store_data;
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) o_wb_we <= 1'b0;
    else o_wb_we <= xm.valid && xm.ctrl.reg_write;
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    o_wb_reg      <= xm.dest;
    mw_alu_result <= xm.alu_result;
    mw_load_data  <= load_data;
    mw_mem_read   <= xm.ctrl.mem_read;
  end

  assign o_wb_data = mw_mem_read ? mw_load_data : mw_alu_result;

  a_dmem_in_range: assert property (
    @(posedge clk) disable iff (!i_rst_n)
    (xm.valid && (xm.ctrl.mem_read || xm.ctrl.mem_write))
      |-> (xm.alu_result < 32'(`MIPS_DMEM_DEPTH * 4)));

endmodule

`default_nettype wire

// File: hdl/mips.sv
`timescale 1ns/1ps
`default_nettype none

module mips
  import mips_isa_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_imem_we,
  input  logic [5:0]  i_imem_addr,
  input  logic [31:0] i_imem_wdata,
  output logic        o_wb_we,
  output logic [4:0]  o_wb_reg,
  output logic [31:0] o_wb_data,
  output logic        o_mispredict
);

  logic        if_valid;
  logic [31:0] if_pc_plus4;
  instr_u      if_instr;
  logic        id_predict_taken;
  logic [31:0] id_predict_target;
  logic        ex_mispredict;
  logic [31:0] ex_redirect_pc;
  logic        wb_we;
  logic [4:0]  wb_reg;
  logic [31:0] wb_data;

  dx_if u_dx ();
  xm_if u_xm ();

  fetch_stage u_fetch (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_imem_we        (i_imem_we),
    .i_imem_addr      (i_imem_addr),
    .i_imem_wdata     (i_imem_wdata),
    .i_predict_taken  (id_predict_taken),
    .i_predict_target (id_predict_target),
    .i_mispredict     (ex_mispredict),
    .i_redirect_pc    (ex_redirect_pc),
    .o_valid          (if_valid),
    .o_pc_plus4       (if_pc_plus4),
    .o_instr          (if_instr)
  );

  decode_stage u_decode (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_valid          (if_valid),
    .i_pc_plus4       (if_pc_plus4),
    .i_instr          (if_instr),
    .i_flush          (ex_mispredict),  // Wrong-path instruction in decode
    .i_wb_we          (wb_we),
    .i_wb_reg         (wb_reg),
    .i_wb_data        (wb_data),
    .o_predict_taken  (id_predict_taken),
    .o_predict_target (id_predict_target),
    .dx               (u_dx.src)
  );

  execute_stage u_execute (
    .clk           (clk),
    .i_rst_n       (i_rst_n),
    .dx            (u_dx.dst),
    .o_mispredict  (ex_mispredict),
    .o_redirect_pc (ex_redirect_pc),
    .xm            (u_xm.src)
  );

  memory_stage u_memory (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .xm        (u_xm.dst),
    .o_wb_we   (wb_we),
    .o_wb_reg  (wb_reg),
    .o_wb_data (wb_data)
  );

  assign o_wb_we      = wb_we;
  assign o_wb_reg     = wb_reg;
  assign o_wb_data    = wb_data;
  assign o_mispredict = ex_mispredict;

endmodule

`default_nettype wire

// File: hdl/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Instruction memory size in 32-bit words
`define MIPS_IMEM_DEPTH 64

// Data memory size in 32-bit words
`define MIPS_DMEM_DEPTH 64

// First fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: hdl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // R-format function field
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  typedef struct packed {
    opcode_e    opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    funct_e     funct;
  } r_view_t;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;  // Sign-extended in decode
  } i_view_t;

  // One instruction word, read as either format
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } instr_u;

endpackage

`default_nettype wire

// File: hdl/mips_pipe_pkg.sv
`default_nettype none

package mips_pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  // Control bits carried with each instruction past decode
  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;    // Second operand is the immediate
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    branch;
  } ctrl_t;

endpackage

`default_nettype wire

// File: hdl/mips_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// ID/EX register contents
interface dx_if
  import mips_pipe_pkg::*;
();
  logic        valid;
  logic [31:0] pc_plus4;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] imm;
  logic [4:0]  dest;
  ctrl_t       ctrl;
  logic        predicted_taken;
  logic [31:0] branch_target;

  modport src (output valid, pc_plus4, rs_data, rt_data, imm, dest, ctrl,
               predicted_taken, branch_target);
  modport dst (input  valid, pc_plus4, rs_data, rt_data, imm, dest, ctrl,
               predicted_taken, branch_target);
endinterface

// EX/MEM register contents
interface xm_if
  import mips_pipe_pkg::*;
();
  logic        valid;
  logic [31:0] alu_result;
  logic [31:0] store_data;
  logic [4:0]  dest;
  ctrl_t       ctrl;

  modport src (output valid, alu_result, store_data, dest, ctrl);
  modport dst (input  valid, alu_result, store_data, dest, ctrl);
endinterface

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/mips_stage_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips.sv
verif/tb_clk_gen.sv
verif/tb_mips.sv

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 10,
  parameter int HOLD_LIMIT = 500
) (
  input  logic i_hold,   // Keeps reset low past RST_CYCLES while the program loads
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    int n;
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    for (n = 0; n < HOLD_LIMIT && i_hold; n++) @(posedge o_clk);
    #1 o_rst_n = 1'b1;  // Released just after an edge
  end

endmodule

`default_nettype wire

// File: verif/tb_mips.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips
  import mips_isa_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 500;

  logic        clk;
  logic        rst_n;
  logic        load_hold;
  logic        imem_we;
  logic [5:0]  imem_addr;
  logic [31:0] imem_wdata;
  logic        wb_we;
  logic [4:0]  wb_reg;
  logic [31:0] wb_data;
  logic        mispredict;

  logic [31:0] prog [$];     // Instruction words in address order
  logic [4:0]  exp_reg [$];  // Expected writebacks in program order
  logic [31:0] exp_val [$];
  logic [4:0]  got_reg [$];
  logic [31:0] got_val [$];

  int mispredict_count = 0;
  int reset_activity   = 0;
  int pass_count       = 0;
  int fail_count       = 0;

  tb_clk_gen u_clk_gen (.i_hold(load_hold), .o_clk(clk), .o_rst_n(rst_n));

  mips DUT (
    .clk          (clk),
    .i_rst_n      (rst_n),
    .i_imem_we    (imem_we),
    .i_imem_addr  (imem_addr),
    .i_imem_wdata (imem_wdata),
    .o_wb_we      (wb_we),
    .o_wb_reg     (wb_reg),
    .o_wb_data    (wb_data),
    .o_mispredict (mispredict)
  );

  function automatic logic [31:0] r_word(funct_e fn, logic [4:0] rd, logic [4:0] rs,
                                         logic [4:0] rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] i_word(opcode_e op, logic [4:0] rt, logic [4:0] rs,
                                         logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic expect_wb(input logic [4:0] r, input logic [31:0] v);
    exp_reg.push_back(r);
    exp_val.push_back(v);
  endtask

  task automatic build_tables();
    prog.push_back(i_word(OP_ADDI, 5'd1, 5'd0, 16'd12));    // r1 = 12
    prog.push_back(i_word(OP_ADDI, 5'd2, 5'd0, 16'd5));     // r2 = 5
    prog.push_back(i_word(OP_ADDI, 5'd10, 5'd0, 16'd1));    // Loop compare value
    prog.push_back(i_word(OP_ADDI, 5'd11, 5'd0, 16'd3));    // Loop limit
    prog.push_back(r_word(FN_ADD, 5'd3, 5'd1, 5'd2));       // r3 = 12 + 5
    prog.push_back(r_word(FN_SUB, 5'd4, 5'd2, 5'd1));       // r4 = 5 - 12
    prog.push_back(r_word(FN_AND, 5'd5, 5'd1, 5'd2));       // r5 = 12 & 5
    prog.push_back(r_word(FN_OR, 5'd6, 5'd1, 5'd2));        // r6 = 12 | 5
    prog.push_back(r_word(FN_SLT, 5'd7, 5'd1, 5'd2));       // 12 < 5 is false
    prog.push_back(r_word(FN_SLT, 5'd8, 5'd4, 5'd2));       // Signed -7 < 5
    prog.push_back(i_word(OP_SW, 5'd3, 5'd0, 16'd8));       // mem[8] = r3
    prog.push_back(i_word(OP_LW, 5'd14, 5'd0, 16'd8));      // r14 = mem[8]
    prog.push_back(i_word(OP_BEQ, 5'd0, 5'd0, 16'd1));      // Forward taken, skips next
    prog.push_back(i_word(OP_ADDI, 5'd9, 5'd0, 16'd99));    // Must never retire
    prog.push_back(i_word(OP_ADDI, 5'd12, 5'd0, 16'd0));    // Counter = 0
    prog.push_back(i_word(OP_ADDI, 5'd0, 5'd0, 16'd77));    // r0 target is discarded
    prog.push_back(32'h0000_0000);
    prog.push_back(i_word(OP_ADDI, 5'd12, 5'd12, 16'd1));   // Loop top (word 17)
    prog.push_back(32'h0000_0000);
    prog.push_back(32'h0000_0000);
    prog.push_back(r_word(FN_SLT, 5'd13, 5'd12, 5'd11));    // r13 = counter < 3
    prog.push_back(32'h0000_0000);
    prog.push_back(32'h0000_0000);
    prog.push_back(i_word(OP_BEQ, 5'd13, 5'd10, 16'hfff9)); // Back to word 17
    prog.push_back(i_word(OP_ADDI, 5'd15, 5'd0, 16'd42));   // After loop exit
    prog.push_back(i_word(OP_BEQ, 5'd0, 5'd0, 16'hffff));   // Halt on itself

    expect_wb(5'd1, 32'd12);
    expect_wb(5'd2, 32'd5);
    expect_wb(5'd10, 32'd1);
    expect_wb(5'd11, 32'd3);
    expect_wb(5'd3, 32'd17);
    expect_wb(5'd4, 32'hffff_fff9);
    expect_wb(5'd5, 32'd4);
    expect_wb(5'd6, 32'd13);
    expect_wb(5'd7, 32'd0);
    expect_wb(5'd8, 32'd1);
    expect_wb(5'd14, 32'd17);    // Load returns the stored sum
    expect_wb(5'd12, 32'd0);
    expect_wb(5'd12, 32'd1);
    expect_wb(5'd13, 32'd1);
    expect_wb(5'd12, 32'd2);
    expect_wb(5'd13, 32'd1);
    expect_wb(5'd12, 32'd3);
    expect_wb(5'd13, 32'd0);     // Loop exits here
    expect_wb(5'd15, 32'd42);
  endtask

  // One word per cycle while the core is held in reset
  task automatic load_program();
    int i;
    for (i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      #1;
      imem_we    = 1'b1;
      imem_addr  = i[5:0];
      imem_wdata = prog[i];
    end
    @(posedge clk);
    #1;
    imem_we   = 1'b0;
    load_hold = 1'b0;
  endtask

  task automatic wait_reset_release(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT_CYCLES && !ok; n++) begin
      @(negedge clk);
      ok = rst_n;
    end
  endtask

  task automatic wait_writebacks(input int count, output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < TIMEOUT_CYCLES && !ok; n++) begin
      @(posedge clk);
      ok = (got_reg.size() >= count);
    end
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) begin
      pass_count++;
      $display("ok      %s = 0x%08h", name, got);
    end else begin
      fail_count++;
      $display("FAILED  t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string ok_text, input string err_text);
    assert (cond) begin
      pass_count++;
      $display("ok      %s", ok_text);
    end else begin
      fail_count++;
      $display("ERROR   %s", err_text);
    end
  endtask

  // Outputs settle mid-cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      if (wb_we === 1'b1 || mispredict === 1'b1) reset_activity++;
    end else begin
      if (wb_we) begin
        got_reg.push_back(wb_reg);
        got_val.push_back(wb_data);
      end
      if (mispredict) mispredict_count++;
    end
  end

  initial begin
    bit ok;
    int i;
    int r0_writes;
    int r9_writes;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    load_hold  = 1'b1;
    r0_writes  = 0;
    r9_writes  = 0;

    build_tables();
    load_program();
    wait_reset_release(ok);
    check_true(ok, "reset released", "reset was never released after the program load");
    if (ok) begin
      wait_writebacks(exp_reg.size(), ok);
      check_true(ok, "all writebacks seen", "timed out waiting for the expected writebacks");
      repeat (20) @(posedge clk);  // Halt loop should stay quiet
    end

    check_eq("reset activity", reset_activity, 0);
    check_eq("writeback count", got_reg.size(), exp_reg.size());
    for (i = 0; i < exp_reg.size(); i++) begin
      if (i < got_reg.size()) begin
        check_eq($sformatf("wb_reg[%0d]", i), 32'(got_reg[i]), 32'(exp_reg[i]));
        check_eq($sformatf("wb_data[%0d]", i), got_val[i], exp_val[i]);
      end else begin
        check_true(1'b0, "", $sformatf("writeback %0d never arrived", i));
      end
    end
    for (i = 0; i < got_reg.size(); i++) begin
      if (got_reg[i] == 5'd0) r0_writes++;
      if (got_reg[i] == 5'd9) r9_writes++;
    end
    check_eq("writes to r0", r0_writes, 0);
    check_eq("writes to skipped r9", r9_writes, 0);
    // Forward taken beq plus the loop's final not-taken exit
    check_eq("mispredict pulses", mispredict_count, 2);

    $display("checks %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
